// ==== source/isa_pkg.sv ====
// rv64 integer subset constants
package isa_pkg;

    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 64'h0;

    // major opcodes of the kept subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // funct3 for alu ops
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] funct3_beq = 3'b000;
    localparam logic [2:0] funct3_bne = 3'b001;

    localparam logic [6:0] funct7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

endpackage

// ==== source/pipe_pkg.sv ====
// pipeline stage and port records
package pipe_pkg;

    import isa_pkg::*;

    // instruction port, core side
    typedef struct packed {
        logic            req;
        logic [xlen-1:0] addr;
    } imem_req_t;

    // instruction port, memory side
    typedef struct packed {
        logic            ack;
        logic [ilen-1:0] data;
    } imem_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [ilen-1:0] inst;
    } fetch_pkt_t;

    // operands already resolved, target precomputed
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
        alu_op_t               alu_op;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
        logic                  is_branch;
        logic                  branch_ne;
        logic                  is_jal;
        logic [xlen-1:0]       target;
    } decode_pkt_t;

    // also serves as the register file write port
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
        logic [xlen-1:0]       data;
    } retire_t;

endpackage

// ==== source/fetch_unit.sv ====
// instruction fetch unit
module fetch_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       redirect,
    input  logic [isa_pkg::xlen-1:0]   redirect_pc,
    input  logic                       stall,
    input  logic                       flush,
    input  pipe_pkg::imem_rsp_t        imem_rsp,
    output pipe_pkg::imem_req_t        imem_req,
    output pipe_pkg::fetch_pkt_t       fetch_pkt
);
    import isa_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_release
    } fetch_state_t;

    fetch_state_t    state;
    logic            req_q;
    logic [xlen-1:0] addr_q;
    logic [xlen-1:0] pc;
    logic            discard;
    logic            buf_valid;
    logic [xlen-1:0] buf_pc;
    logic [ilen-1:0] buf_inst;
    logic            can_issue;
    logic            issue;
    logic            accept;
    logic            capture;

    // buffer must be empty or draining before a new request goes out
    assign can_issue = !redirect && (!buf_valid || !stall);
    assign issue     = can_issue &&
                       (state == st_idle || (state == st_release && !imem_rsp.ack));
    assign accept    = (state == st_wait_ack) && imem_rsp.ack;
    assign capture   = accept && !discard && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            req_q   <= 1'b0;
            pc      <= reset_pc;
            discard <= 1'b0;
        end else begin
            case (state)
                st_idle:     if (issue) state <= st_wait_ack;
                st_wait_ack: if (imem_rsp.ack) state <= st_release;
                st_release:  if (!imem_rsp.ack) state <= issue ? st_wait_ack : st_idle;
                default:     state <= st_idle;
            endcase

            if (issue) begin
                req_q <= 1'b1;
            end else if (accept) begin
                req_q <= 1'b0;
            end

            if (redirect) begin
                pc <= redirect_pc;
            end else if (issue) begin
                pc <= pc + xlen'(4);
            end

            // wrong-path fetch still in flight, let it finish and drop it
            if (accept) begin
                discard <= 1'b0;
            end else if (redirect && state == st_wait_ack) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            buf_valid <= 1'b0;
        end else if (capture) begin
            buf_valid <= 1'b1;
        end else if (!stall) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_pc   <= addr_q;
            buf_inst <= imem_rsp.data;
        end
    end

    assign imem_req  = '{req: req_q, addr: addr_q};
    assign fetch_pkt = '{valid: buf_valid, pc: buf_pc, inst: buf_inst};

    addr_hold_a: assert property (@(posedge clk) disable iff (reset)
        imem_req.req && !imem_rsp.ack |=> imem_req.req && $stable(imem_req.addr));

endmodule

// ==== source/decode_unit.sv ====
// instruction decode and operand read
module decode_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  pipe_pkg::fetch_pkt_t            fetch_pkt,
    input  logic                            stall,
    input  logic                            flush,
    output logic [isa_pkg::reg_addr_w-1:0]  rs1_addr,
    output logic [isa_pkg::reg_addr_w-1:0]  rs2_addr,
    output logic                            rs1_used,
    output logic                            rs2_used,
    input  logic [isa_pkg::xlen-1:0]        rs1_data,
    input  logic [isa_pkg::xlen-1:0]        rs2_data,
    output pipe_pkg::decode_pkt_t           decode_pkt
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    decode_pkt_t     dec_d;
    decode_pkt_t     dec_q;

    assign opcode   = fetch_pkt.inst[6:0];
    assign funct3   = fetch_pkt.inst[14:12];
    assign funct7   = fetch_pkt.inst[31:25];
    assign rs1_addr = fetch_pkt.inst[19:15];
    assign rs2_addr = fetch_pkt.inst[24:20];

    assign imm_i = {{52{fetch_pkt.inst[31]}}, fetch_pkt.inst[31:20]};
    assign imm_u = {{32{fetch_pkt.inst[31]}}, fetch_pkt.inst[31:12], 12'b0};
    assign imm_b = {{51{fetch_pkt.inst[31]}}, fetch_pkt.inst[31], fetch_pkt.inst[7],
                    fetch_pkt.inst[30:25], fetch_pkt.inst[11:8], 1'b0};
    assign imm_j = {{43{fetch_pkt.inst[31]}}, fetch_pkt.inst[31], fetch_pkt.inst[19:12],
                    fetch_pkt.inst[20], fetch_pkt.inst[30:21], 1'b0};

    // source usage feeds the hazard check
    assign rs1_used = fetch_pkt.valid &&
                      (opcode == op_reg || opcode == op_imm || opcode == op_branch);
    assign rs2_used = fetch_pkt.valid && (opcode == op_reg || opcode == op_branch);

    always_comb begin
        dec_d        = '0;
        dec_d.valid  = fetch_pkt.valid;
        dec_d.pc     = fetch_pkt.pc;
        dec_d.rd     = fetch_pkt.inst[11:7];
        dec_d.alu_op = alu_add;
        dec_d.op_a   = rs1_data;
        dec_d.op_b   = rs2_data;
        dec_d.target = fetch_pkt.pc + imm_b;
        case (opcode)
            op_reg: begin
                if (funct7 == 7'b0) begin
                    dec_d.wen = 1'b1;
                    case (funct3)
                        funct3_add_sub: dec_d.alu_op = alu_add;
                        funct3_xor:     dec_d.alu_op = alu_xor;
                        funct3_or:      dec_d.alu_op = alu_or;
                        funct3_and:     dec_d.alu_op = alu_and;
                        default:        dec_d.wen = 1'b0;
                    endcase
                end else if (funct7 == funct7_sub && funct3 == funct3_add_sub) begin
                    dec_d.wen    = 1'b1;
                    dec_d.alu_op = alu_sub;
                end
            end
            op_imm: begin
                // addi only
                if (funct3 == funct3_add_sub) begin
                    dec_d.wen  = 1'b1;
                    dec_d.op_b = imm_i;
                end
            end
            op_lui: begin
                dec_d.wen    = 1'b1;
                dec_d.alu_op = alu_pass_b;
                dec_d.op_b   = imm_u;
            end
            op_branch: begin
                dec_d.is_branch = (funct3 == funct3_beq) || (funct3 == funct3_bne);
                dec_d.branch_ne = (funct3 == funct3_bne);
            end
            op_jal: begin
                // link value is pc + 4 through the adder
                dec_d.wen    = 1'b1;
                dec_d.is_jal = 1'b1;
                dec_d.op_a   = fetch_pkt.pc;
                dec_d.op_b   = xlen'(4);
                dec_d.target = fetch_pkt.pc + imm_j;
            end
            default: ;
        endcase
        dec_d.wen = dec_d.wen && fetch_pkt.valid;
    end

    always_ff @(posedge clk) begin
        if (reset || flush || stall) begin
            dec_q.valid <= 1'b0;
            dec_q.wen   <= 1'b0;
        end else begin
            dec_q <= dec_d;
        end
    end

    assign decode_pkt = dec_q;

endmodule

// ==== source/reg_file.sv ====
// integer register file
module reg_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [isa_pkg::reg_addr_w-1:0]  rs1_addr,
    input  logic [isa_pkg::reg_addr_w-1:0]  rs2_addr,
    output logic [isa_pkg::xlen-1:0]        rs1_data,
    output logic [isa_pkg::xlen-1:0]        rs2_data,
    input  pipe_pkg::retire_t               wb
);
    import isa_pkg::*;

    logic [xlen-1:0] regs [32];
    logic            wr_en;

    assign wr_en = !reset && wb.valid && wb.wen && (wb.rd != '0);

    // x0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (reset) begin
            regs[0] <= '0;
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // retire record is visible to readers in the cycle it is presented
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        logic [xlen-1:0] value;
        if (wr_en && wb.rd == addr) begin
            value = wb.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    x0_zero_a: assert property (@(posedge clk) disable iff (reset)
        (rs1_addr != '0 || rs1_data == '0) && (rs2_addr != '0 || rs2_data == '0));

endmodule

// ==== source/execute_unit.sv ====
// execute stage and retire register
module execute_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  pipe_pkg::decode_pkt_t       decode_pkt,
    output logic                        redirect,
    output logic [isa_pkg::xlen-1:0]    redirect_pc,
    output pipe_pkg::retire_t           retire
);
    import isa_pkg::*;

    logic [xlen-1:0]       alu_res;
    logic                  operands_eq;
    logic                  branch_taken;
    logic                  ret_valid;
    logic                  ret_wen;
    logic [xlen-1:0]       ret_pc;
    logic [reg_addr_w-1:0] ret_rd;
    logic [xlen-1:0]       ret_data;

    always_comb begin
        case (decode_pkt.alu_op)
            alu_add:    alu_res = decode_pkt.op_a + decode_pkt.op_b;
            alu_sub:    alu_res = decode_pkt.op_a - decode_pkt.op_b;
            alu_and:    alu_res = decode_pkt.op_a & decode_pkt.op_b;
            alu_or:     alu_res = decode_pkt.op_a | decode_pkt.op_b;
            alu_xor:    alu_res = decode_pkt.op_a ^ decode_pkt.op_b;
            alu_pass_b: alu_res = decode_pkt.op_b;
            default:    alu_res = decode_pkt.op_a + decode_pkt.op_b;
        endcase
    end

    // beq / bne compare rs1 against rs2
    assign operands_eq  = (decode_pkt.op_a == decode_pkt.op_b);
    assign branch_taken = decode_pkt.is_branch && (operands_eq != decode_pkt.branch_ne);

    assign redirect    = decode_pkt.valid && (branch_taken || decode_pkt.is_jal);
    assign redirect_pc = decode_pkt.target;

    always_ff @(posedge clk) begin
        if (reset) begin
            ret_valid <= 1'b0;
            ret_wen   <= 1'b0;
        end else begin
            ret_valid <= decode_pkt.valid;
            ret_wen   <= decode_pkt.valid && decode_pkt.wen;
        end
    end

    always_ff @(posedge clk) begin
        ret_pc   <= decode_pkt.pc;
        ret_rd   <= decode_pkt.rd;
        ret_data <= alu_res;
    end

    assign retire = '{valid: ret_valid, pc: ret_pc, rd: ret_rd, wen: ret_wen, data: ret_data};

endmodule

// ==== source/pipe_ctrl.sv ====
// hazard stall and redirect flush
module pipe_ctrl (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            fetch_valid,
    input  logic [isa_pkg::reg_addr_w-1:0]  rs1_addr,
    input  logic [isa_pkg::reg_addr_w-1:0]  rs2_addr,
    input  logic                            rs1_used,
    input  logic                            rs2_used,
    input  logic [isa_pkg::reg_addr_w-1:0]  ex_rd,
    input  logic                            ex_wen,
    input  logic                            redirect,
    output logic                            stall,
    output logic                            flush
);

    logic rs1_hazard;
    logic rs2_hazard;

    // producer sitting in the decode register has not written yet
    assign rs1_hazard = rs1_used && (rs1_addr != '0) && (rs1_addr == ex_rd);
    assign rs2_hazard = rs2_used && (rs2_addr != '0) && (rs2_addr == ex_rd);

    assign flush = redirect;
    assign stall = fetch_valid && ex_wen && (rs1_hazard || rs2_hazard) && !flush;

    // the bubble behind a stall clears the hazard
    stall_once_a: assert property (@(posedge clk) disable iff (reset)
        stall |=> !stall);

    // flush empties the fetch buffer, nothing left to stall on
    flush_no_stall_a: assert property (@(posedge clk) disable iff (reset)
        flush |=> !stall);

endmodule

// ==== source/core_top.sv ====
// rv64 integer pipeline top
module core_top (
    input  logic                    clk,
    input  logic                    reset,
    output pipe_pkg::imem_req_t     imem_req,
    input  pipe_pkg::imem_rsp_t     imem_rsp,
    output pipe_pkg::retire_t       retire
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fetch_pkt_t            fetch_pkt;
    decode_pkt_t           decode_pkt;
    logic                  redirect;
    logic [xlen-1:0]       redirect_pc;
    logic                  stall;
    logic                  flush;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic                  rs1_used;
    logic                  rs2_used;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;

    fetch_unit u_fetch (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .redirect    ( redirect    ),
        .redirect_pc ( redirect_pc ),
        .stall       ( stall       ),
        .flush       ( flush       ),
        .imem_rsp    ( imem_rsp    ),
        .imem_req    ( imem_req    ),
        .fetch_pkt   ( fetch_pkt   )
    );

    decode_unit u_decode (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .fetch_pkt   ( fetch_pkt   ),
        .stall       ( stall       ),
        .flush       ( flush       ),
        .rs1_addr    ( rs1_addr    ),
        .rs2_addr    ( rs2_addr    ),
        .rs1_used    ( rs1_used    ),
        .rs2_used    ( rs2_used    ),
        .rs1_data    ( rs1_data    ),
        .rs2_data    ( rs2_data    ),
        .decode_pkt  ( decode_pkt  )
    );

    reg_file u_regs (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .rs1_addr    ( rs1_addr    ),
        .rs2_addr    ( rs2_addr    ),
        .rs1_data    ( rs1_data    ),
        .rs2_data    ( rs2_data    ),
        .wb          ( retire      )
    );

    execute_unit u_execute (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .decode_pkt  ( decode_pkt  ),
        .redirect    ( redirect    ),
        .redirect_pc ( redirect_pc ),
        .retire      ( retire      )
    );

    pipe_ctrl u_ctrl (
        .clk         ( clk              ),
        .reset       ( reset            ),
        .fetch_valid ( fetch_pkt.valid  ),
        .rs1_addr    ( rs1_addr         ),
        .rs2_addr    ( rs2_addr         ),
        .rs1_used    ( rs1_used         ),
        .rs2_used    ( rs2_used         ),
        .ex_rd       ( decode_pkt.rd    ),
        .ex_wen      ( decode_pkt.wen   ),
        .redirect    ( redirect         ),
        .stall       ( stall            ),
        .flush       ( flush            )
    );

endmodule

// ==== tests/imem_responder.sv ====
// instruction memory model
module imem_responder #(
    parameter int          prog_len  = 31,
    parameter int          max_delay = 4,
    parameter int unsigned seed      = 32'h1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  pipe_pkg::imem_req_t  imem_req,
    output pipe_pkg::imem_rsp_t  imem_rsp
);
    import isa_pkg::*;

    logic [ilen-1:0] prog [prog_len];
    int unsigned     wait_cycles;

    function automatic logic [ilen-1:0] alu_rr(input logic [2:0] funct3,
                                               input logic [6:0] funct7,
                                               input int rd, input int rs1, input int rs2);
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], op_reg};
    endfunction

    function automatic logic [ilen-1:0] addi_word(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], funct3_add_sub, rd[4:0], op_imm};
    endfunction

    function automatic logic [ilen-1:0] lui_word(input int rd, input int imm);
        return {imm[19:0], rd[4:0], op_lui};
    endfunction

    function automatic logic [ilen-1:0] branch_word(input logic [2:0] funct3,
                                                    input int rs1, input int rs2,
                                                    input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], funct3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [ilen-1:0] jal_word(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
    endfunction

    // words past the program come from a hash of the address
    function automatic logic [ilen-1:0] word_at(input logic [xlen-1:0] addr);
        logic [ilen-1:0] word;
        if (addr < 64'(prog_len * 4)) begin
            word = prog[addr >> 2];
        end else begin
            word = addr[31:0] ^ addr[63:32] ^ 32'hc3a5_0f0f;
        end
        return word;
    endfunction

    initial begin
        prog[0]  = addi_word(1, 0, 5);
        prog[1]  = addi_word(2, 0, -3);
        prog[2]  = alu_rr(funct3_add_sub, 7'b0, 3, 1, 2);
        prog[3]  = alu_rr(funct3_add_sub, funct7_sub, 4, 3, 1);
        prog[4]  = alu_rr(funct3_xor, 7'b0, 5, 4, 2);
        prog[5]  = alu_rr(funct3_or, 7'b0, 6, 1, 3);
        prog[6]  = alu_rr(funct3_and, 7'b0, 7, 6, 1);
        prog[7]  = lui_word(8, 32'h12345);
        prog[8]  = addi_word(8, 8, 32'h678);
        prog[9]  = addi_word(0, 1, 7);
        prog[10] = alu_rr(funct3_add_sub, 7'b0, 9, 0, 1);
        prog[11] = branch_word(funct3_beq, 7, 1, 8);
        prog[12] = addi_word(10, 0, 1);
        prog[13] = branch_word(funct3_bne, 7, 1, 8);
        prog[14] = addi_word(11, 0, 9);
        prog[15] = branch_word(funct3_bne, 11, 0, 12);
        prog[16] = addi_word(10, 0, 2);
        prog[17] = addi_word(10, 0, 3);
        prog[18] = jal_word(12, 8);
        prog[19] = addi_word(10, 0, 4);
        prog[20] = lui_word(13, 32'hfffff);
        prog[21] = alu_rr(funct3_add_sub, funct7_sub, 14, 0, 13);
        // fence, outside the subset
        prog[22] = 32'h0000_000f;
        prog[23] = alu_rr(funct3_add_sub, 7'b0, 15, 14, 12);
        prog[24] = addi_word(16, 0, 3);
        prog[25] = addi_word(16, 16, -1);
        prog[26] = branch_word(funct3_bne, 16, 0, -4);
        prog[27] = jal_word(0, 8);
        prog[28] = addi_word(10, 0, 5);
        prog[29] = alu_rr(funct3_xor, 7'b0, 17, 15, 13);
        prog[30] = jal_word(0, 0);
    end

    initial begin
        imem_rsp = '0;
        void'($urandom(seed));
        forever begin
            @(negedge clk);
            if (!reset && imem_req.req && !imem_rsp.ack) begin
                wait_cycles = $urandom % (max_delay + 1);
                repeat (wait_cycles) @(negedge clk);
                imem_rsp.data = word_at(imem_req.addr);
                imem_rsp.ack  = 1'b1;
                // hold ack until the core lets go of req
                do begin
                    @(negedge clk);
                end while (imem_req.req);
                imem_rsp.ack = 1'b0;
            end
        end
    end

endmodule

// ==== tests/tb_core_top.sv ====
// core pipeline testbench
module tb_core_top;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int              clk_period       = 100;
    localparam int              prog_len         = 31;
    localparam int              max_delay        = 4;
    localparam int unsigned     rng_seed         = 32'h910a_b9c1;
    localparam logic [xlen-1:0] final_pc         = 64'd120;
    localparam int              watchdog_cycles  = prog_len * (max_delay + 6) + 20;

    logic                  clk;
    logic                  reset;
    imem_req_t             imem_req;
    imem_rsp_t             imem_rsp;
    retire_t               retire;
    logic                  first_req_seen;
    logic                  first_ack_seen;
    logic [xlen-1:0]       model_pc;
    logic [xlen-1:0]       model_regs [32];
    logic [ilen-1:0]       cur_inst;
    logic [6:0]            cur_opcode;
    logic [2:0]            cur_funct3;
    logic [6:0]            cur_funct7;
    logic [reg_addr_w-1:0] cur_rd;
    logic [xlen-1:0]       src_a;
    logic [xlen-1:0]       src_b;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_u;
    logic [xlen-1:0]       imm_b;
    logic [xlen-1:0]       imm_j;
    logic                  exp_wen;
    logic [xlen-1:0]       exp_data;
    logic [xlen-1:0]       exp_next_pc;

    core_top dut_i (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .imem_req ( imem_req ),
        .imem_rsp ( imem_rsp ),
        .retire   ( retire   )
    );

    imem_responder #(
        .prog_len  ( prog_len  ),
        .max_delay ( max_delay ),
        .seed      ( rng_seed  )
    ) mem_i (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .imem_req ( imem_req ),
        .imem_rsp ( imem_rsp )
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        stop_with_error("timeout: the program did not reach its final jump in time");
    end

    // golden model decodes the instruction at its own pc
    assign cur_inst   = mem_i.prog[model_pc[6:2]];
    assign cur_opcode = cur_inst[6:0];
    assign cur_funct3 = cur_inst[14:12];
    assign cur_funct7 = cur_inst[31:25];
    assign cur_rd     = cur_inst[11:7];
    assign src_a      = model_regs[cur_inst[19:15]];
    assign src_b      = model_regs[cur_inst[24:20]];
    assign imm_i      = {{52{cur_inst[31]}}, cur_inst[31:20]};
    assign imm_u      = {{32{cur_inst[31]}}, cur_inst[31:12], 12'b0};
    assign imm_b      = {{51{cur_inst[31]}}, cur_inst[31], cur_inst[7], cur_inst[30:25],
                         cur_inst[11:8], 1'b0};
    assign imm_j      = {{43{cur_inst[31]}}, cur_inst[31], cur_inst[19:12], cur_inst[20],
                         cur_inst[30:21], 1'b0};

    always_comb begin
        exp_wen     = 1'b0;
        exp_data    = '0;
        exp_next_pc = model_pc + 64'd4;
        if (cur_opcode == op_reg && cur_funct7 == 7'b0) begin
            exp_wen = 1'b1;
            case (cur_funct3)
                3'b000:  exp_data = src_a + src_b;
                3'b100:  exp_data = src_a ^ src_b;
                3'b110:  exp_data = src_a | src_b;
                3'b111:  exp_data = src_a & src_b;
                default: exp_wen = 1'b0;
            endcase
        end else if (cur_opcode == op_reg && cur_funct7 == 7'b0100000 && cur_funct3 == 3'b0) begin
            exp_wen  = 1'b1;
            exp_data = src_a - src_b;
        end else if (cur_opcode == op_imm && cur_funct3 == 3'b000) begin
            exp_wen  = 1'b1;
            exp_data = src_a + imm_i;
        end else if (cur_opcode == op_lui) begin
            exp_wen  = 1'b1;
            exp_data = imm_u;
        end else if (cur_opcode == op_branch) begin
            if ((cur_funct3 == 3'b000 && src_a == src_b) ||
                (cur_funct3 == 3'b001 && src_a != src_b)) begin
                exp_next_pc = model_pc + imm_b;
            end
        end else if (cur_opcode == op_jal) begin
            exp_wen     = 1'b1;
            exp_data    = model_pc + 64'd4;
            exp_next_pc = model_pc + imm_j;
        end
        // x0 ignores writes
        if (cur_rd == '0) begin
            exp_wen = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            model_pc <= reset_pc;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] <= '0;
            end
        end else if (retire.valid) begin
            model_pc <= exp_next_pc;
            if (exp_wen) begin
                model_regs[cur_rd] <= exp_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            first_req_seen <= 1'b0;
            first_ack_seen <= 1'b0;
        end else begin
            first_req_seen <= first_req_seen || imem_req.req;
            first_ack_seen <= first_ack_seen || imem_rsp.ack;
        end
    end

    first_req_addr_a: assert property (@(posedge clk) disable iff (reset)
        imem_req.req && !first_req_seen |-> imem_req.addr == reset_pc)
        else stop_with_error($sformatf("mismatch at %0t: first request address %h",
                                       $time, $sampled(imem_req.addr)));

    no_early_retire_a: assert property (@(posedge clk) disable iff (reset)
        !first_ack_seen |-> !retire.valid)
        else stop_with_error("retire valid went high before any instruction was fetched");

    retire_pc_a: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> retire.pc == model_pc)
        else stop_with_error($sformatf("mismatch at %0t: retired pc %h, expected %h",
                                       $time, $sampled(retire.pc), $sampled(model_pc)));

    retire_write_a: assert property (@(posedge clk) disable iff (reset)
        retire.valid && exp_wen |->
            retire.wen && retire.rd == cur_rd && retire.data == exp_data)
        else stop_with_error($sformatf("mismatch at %0t: x%0d got %h, expected x%0d = %h",
                                       $time, $sampled(retire.rd), $sampled(retire.data),
                                       $sampled(cur_rd), $sampled(exp_data)));

    retire_no_write_a: assert property (@(posedge clk) disable iff (reset)
        retire.valid && !exp_wen |-> !(retire.wen && retire.rd != '0))
        else stop_with_error($sformatf("mismatch at %0t: pc %h wrote x%0d, expected no write",
                                       $time, $sampled(retire.pc), $sampled(retire.rd)));

    req_hold_a: assert property (@(posedge clk) disable iff (reset)
        imem_req.req && !imem_rsp.ack |=> imem_req.req && $stable(imem_req.addr))
        else stop_with_error("request dropped or its address changed before ack");

    req_fall_a: assert property (@(posedge clk) disable iff (reset)
        $fell(imem_req.req) |-> $past(imem_rsp.ack))
        else stop_with_error("request fell without an ack from the memory");

    req_rise_a: assert property (@(posedge clk) disable iff (reset)
        $rose(imem_req.req) |-> !$past(imem_rsp.ack))
        else stop_with_error("request rose while ack was still high");

    initial begin
        @(negedge clk);
        while (reset || model_pc != final_pc) begin
            @(negedge clk);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/pipe_ctrl.sv
source/core_top.sv
tests/imem_responder.sv
tests/tb_core_top.sv

// ==== Bender.yml ====
package:
  name: rv64_mini_core

sources:
  - files:
      - source/isa_pkg.sv
      - source/pipe_pkg.sv
      - source/fetch_unit.sv
      - source/decode_unit.sv
      - source/reg_file.sv
      - source/execute_unit.sv
      - source/pipe_ctrl.sv
      - source/core_top.sv
  - target: test
    files:
      - tests/imem_responder.sv
      - tests/tb_core_top.sv
